// File: common/cpuPkg.sv
// -------------------------------------------------------------------------
// cpu package
// opcode, function, ALU operation and access size encodings of the
// DLX-style core, and the instruction field positions (bit 0 is the MSB)
// -------------------------------------------------------------------------
package cpuPkg;

    // primary opcode, instr[0:5]
    typedef enum logic [5:0] {
        rType = 6'h00,
        j     = 6'h02,
        jal   = 6'h03,
        beqz  = 6'h04,
        bnez  = 6'h05,
        addi  = 6'h08,
        andi  = 6'h0C,
        ori   = 6'h0D,
        lhi   = 6'h0F,
        jr    = 6'h12,
        lb    = 6'h20,
        lh    = 6'h21,
        lw    = 6'h23,
        lbu   = 6'h24,
        lhu   = 6'h25,
        sb    = 6'h28,
        sw    = 6'h2B
    } opcodeE;

    // function field of the R-type instructions, instr[26:31]
    typedef enum logic [5:0] {
        funcSll  = 6'h04,
        funcSrl  = 6'h06,
        funcSra  = 6'h07,
        funcMult = 6'h0E,
        funcAdd  = 6'h20,
        funcSub  = 6'h22,
        funcAnd  = 6'h24,
        funcOr   = 6'h25,
        funcXor  = 6'h26,
        funcSlt  = 6'h2A
    } funcE;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor,
        aluSll, aluSrl, aluSra, aluSlt, aluPassB
    } aluOpE;

    // halfword code is only produced by loads
    typedef enum logic [1:0] {
        sizeByte = 2'b00,
        sizeHalf = 2'b01,
        sizeWord = 2'b10
    } dataSizeE;

    localparam logic [0:4] linkReg = 5'd31;
    localparam logic [0:31] lhiShift = 32'd16;

    // field start positions and widths, big-endian numbering
    localparam int opcodePos = 0;
    localparam int rs1Pos = 6;
    localparam int rs2Pos = 11;
    localparam int rdPos = 16;
    localparam int funcPos = 26;
    localparam int imm16Pos = 16;
    localparam int imm26Pos = 6;
    localparam int opcodeWidth = 6;
    localparam int regIdxWidth = 5;

endpackage

// File: common/execIf.sv
// -------------------------------------------------------------------------
// execute interface
// operands and operation from the core, result back from the execute unit
// -------------------------------------------------------------------------
interface execIf;

    logic [0:31] operandA;
    logic [0:31] operandB;
    cpuPkg::aluOpE aluOp;
    // selects the product instead of the ALU result
    logic isMul;
    logic [0:31] result;

    modport core (output operandA, operandB, aluOp, isMul, input result);

    modport unit (input operandA, operandB, aluOp, isMul, output result);

endinterface

// File: logic/instrDecoder.sv
// -------------------------------------------------------------------------
// instruction decoder
// turns opcode and function field into the control set of one instruction
// -------------------------------------------------------------------------
module instrDecoder (
    input  logic             rstN,
    input  logic [0:31]      instr,
    output logic             rType,
    output logic             regWrite,
    output logic             memToReg,
    output logic             memWrite,
    output logic             loadSigned,
    output cpuPkg::dataSizeE dataSize,
    output cpuPkg::aluOpE    aluOp,
    output logic             isMul,
    output logic             zeroExt,
    output logic             isLhi,
    output logic             branch,
    output logic             branchOnZero,
    output logic             jump,
    output logic             jumpReg,
    output logic             link
);

    cpuPkg::opcodeE opcode;
    cpuPkg::funcE func;
    logic regWriteRaw;
    logic memWriteRaw;

    assign opcode = cpuPkg::opcodeE'(instr[cpuPkg::opcodePos +: cpuPkg::opcodeWidth]);
    assign func = cpuPkg::funcE'(instr[cpuPkg::funcPos +: cpuPkg::opcodeWidth]);

    always_comb begin
        // defaults form a no-op
        rType = 1'b0;
        regWriteRaw = 1'b0;
        memToReg = 1'b0;
        memWriteRaw = 1'b0;
        loadSigned = 1'b0;
        dataSize = cpuPkg::sizeWord;
        aluOp = cpuPkg::aluPassB;
        isMul = 1'b0;
        zeroExt = 1'b0;
        isLhi = 1'b0;
        branch = 1'b0;
        branchOnZero = 1'b0;
        jump = 1'b0;
        jumpReg = 1'b0;
        link = 1'b0;
        case (opcode)
            cpuPkg::rType: begin
                rType = 1'b1;
                regWriteRaw = 1'b1;
                case (func)
                    cpuPkg::funcAdd: aluOp = cpuPkg::aluAdd;
                    cpuPkg::funcSub: aluOp = cpuPkg::aluSub;
                    cpuPkg::funcAnd: aluOp = cpuPkg::aluAnd;
                    cpuPkg::funcOr: aluOp = cpuPkg::aluOr;
                    cpuPkg::funcXor: aluOp = cpuPkg::aluXor;
                    cpuPkg::funcSll: aluOp = cpuPkg::aluSll;
                    cpuPkg::funcSrl: aluOp = cpuPkg::aluSrl;
                    cpuPkg::funcSra: aluOp = cpuPkg::aluSra;
                    cpuPkg::funcSlt: aluOp = cpuPkg::aluSlt;
                    cpuPkg::funcMult: isMul = 1'b1;
                    // unknown function, nothing written
                    default: regWriteRaw = 1'b0;
                endcase
            end
            cpuPkg::addi: begin
                regWriteRaw = 1'b1;
                aluOp = cpuPkg::aluAdd;
            end
            cpuPkg::andi, cpuPkg::ori: begin
                regWriteRaw = 1'b1;
                zeroExt = 1'b1;
                aluOp = (opcode == cpuPkg::andi) ? cpuPkg::aluAnd : cpuPkg::aluOr;
            end
            // immediate goes to operand A and is shifted up by 16
            cpuPkg::lhi: begin
                regWriteRaw = 1'b1;
                isLhi = 1'b1;
                aluOp = cpuPkg::aluSll;
            end
            cpuPkg::lb, cpuPkg::lbu, cpuPkg::lh, cpuPkg::lhu, cpuPkg::lw: begin
                regWriteRaw = 1'b1;
                memToReg = 1'b1;
                aluOp = cpuPkg::aluAdd;
                loadSigned = (opcode == cpuPkg::lb) || (opcode == cpuPkg::lh);
                if (opcode == cpuPkg::lb || opcode == cpuPkg::lbu) begin
                    dataSize = cpuPkg::sizeByte;
                end else if (opcode == cpuPkg::lh || opcode == cpuPkg::lhu) begin
                    dataSize = cpuPkg::sizeHalf;
                end
            end
            cpuPkg::sb, cpuPkg::sw: begin
                memWriteRaw = 1'b1;
                aluOp = cpuPkg::aluAdd;
                dataSize = (opcode == cpuPkg::sb) ? cpuPkg::sizeByte : cpuPkg::sizeWord;
            end
            cpuPkg::beqz, cpuPkg::bnez: begin
                branch = 1'b1;
                branchOnZero = (opcode == cpuPkg::beqz);
            end
            cpuPkg::j: jump = 1'b1;
            cpuPkg::jal: begin
                jump = 1'b1;
                link = 1'b1;
                regWriteRaw = 1'b1;
            end
            cpuPkg::jr: jumpReg = 1'b1;
            default: ;
        endcase
    end

    // no architectural writes while the core is held in reset
    assign regWrite = regWriteRaw & rstN;
    assign memWrite = memWriteRaw & rstN;

    always_comb begin
        assert (!(memWrite && regWrite))
            else $error("decoder raised memWrite and regWrite together");
    end

endmodule

// File: logic/registerFile.sv
// -------------------------------------------------------------------------
// register file
// 32 x 32-bit, two combinational reads, one write on the clock edge
// -------------------------------------------------------------------------
module registerFile (
    input  logic        clk,
    input  logic        rstN,
    input  logic [0:4]  rdAddrA,
    input  logic [0:4]  rdAddrB,
    input  logic [0:4]  wrAddr,
    input  logic [0:31] wrData,
    input  logic        wrEn,
    output logic [0:31] busA,
    output logic [0:31] busB
);

    logic [0:31] regs [0:31];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrAddr != '0) begin
            // r0 is hardwired, writes to it are dropped
            regs[wrAddr] <= wrData;
        end
    end

    assign busA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
    assign busB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

    // a write is visible on port A in the following cycle
    assert property (@(posedge clk) disable iff (!rstN)
        (wrEn && wrAddr != '0) |=> (rdAddrA != $past(wrAddr) || busA == $past(wrData)))
        else $error("register read after write returned stale data");

endmodule

// File: logic/pcLogic.sv
// -------------------------------------------------------------------------
// program counter
// holds the PC, resolves branches and jumps, provides the link address
// -------------------------------------------------------------------------
module pcLogic (
    input  logic        clk,
    input  logic        rstN,
    input  logic [0:15] imm16,
    input  logic [0:25] imm26,
    input  logic [0:31] busA,
    input  logic        branch,
    input  logic        branchOnZero,
    input  logic        jump,
    input  logic        jumpReg,
    output logic [0:31] pc,
    output logic [0:31] linkAddr
);

    logic [0:31] branchOffset;
    logic [0:31] jumpOffset;
    logic [0:31] nextPc;
    logic branchTaken;

    // sequential address, also what JAL saves
    assign linkAddr = pc + 32'd4;

    assign branchOffset = {{16{imm16[0]}}, imm16};
    assign jumpOffset = {{6{imm26[0]}}, imm26};

    // BEQZ takes on zero, BNEZ on nonzero
    assign branchTaken = branch && ((busA == '0) == branchOnZero);

    always_comb begin
        if (jumpReg) begin
            nextPc = busA;
        end else if (jump) begin
            nextPc = linkAddr + jumpOffset;
        end else if (branchTaken) begin
            nextPc = linkAddr + branchOffset;
        end else begin
            nextPc = linkAddr;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
        end else begin
            pc <= nextPc;
        end
    end

    // a misaligned JR target or offset would break this
    assert property (@(posedge clk) disable iff (!rstN) pc[30:31] == 2'b00)
        else $error("PC left word alignment");

endmodule

// File: execute/executeUnit.sv
// -------------------------------------------------------------------------
// execute unit
// ALU and signed 32-bit multiplier in parallel, result picked by isMul
// -------------------------------------------------------------------------
module executeUnit (
    execIf.unit ex
);

    logic [0:31] aluResult;
    logic [0:31] product;
    logic [0:4] shamt;

    // shift amount is the low five bits of B
    assign shamt = ex.operandB[27:31];

    always_comb begin
        case (ex.aluOp)
            cpuPkg::aluAdd: aluResult = ex.operandA + ex.operandB;
            cpuPkg::aluSub: aluResult = ex.operandA - ex.operandB;
            cpuPkg::aluAnd: aluResult = ex.operandA & ex.operandB;
            cpuPkg::aluOr: aluResult = ex.operandA | ex.operandB;
            cpuPkg::aluXor: aluResult = ex.operandA ^ ex.operandB;
            cpuPkg::aluSll: aluResult = ex.operandA << shamt;
            cpuPkg::aluSrl: aluResult = ex.operandA >> shamt;
            // arithmetic shift keeps the sign bit (bit 0)
            cpuPkg::aluSra: aluResult = $signed(ex.operandA) >>> shamt;
            cpuPkg::aluSlt: begin
                aluResult = {31'b0, $signed(ex.operandA) < $signed(ex.operandB)};
            end
            cpuPkg::aluPassB: aluResult = ex.operandB;
            default: aluResult = ex.operandB;
        endcase
    end

    // low word of the signed product
    assign product = $signed(ex.operandA) * $signed(ex.operandB);

    assign ex.result = ex.isMul ? product : aluResult;

endmodule

// File: logic/loadAligner.sv
// -------------------------------------------------------------------------
// load aligner
// picks byte, halfword or word from the read word and extends it
// -------------------------------------------------------------------------
module loadAligner (
    input  logic [0:31]      rawData,
    input  logic [0:1]       byteOffset,
    input  cpuPkg::dataSizeE dataSize,
    input  logic             loadSigned,
    output logic [0:31]      loadData
);

    logic [0:7] selByte;
    logic [0:15] selHalf;

    // big-endian, offset 0 is the most significant byte
    assign selByte = rawData[byteOffset * 8 +: 8];
    assign selHalf = byteOffset[0] ? rawData[16:31] : rawData[0:15];

    always_comb begin
        case (dataSize)
            cpuPkg::sizeByte: loadData = {{24{loadSigned & selByte[0]}}, selByte};
            cpuPkg::sizeHalf: loadData = {{16{loadSigned & selHalf[0]}}, selHalf};
            default: loadData = rawData;
        endcase
    end

endmodule

// File: logic/regWriteback.sv
// -------------------------------------------------------------------------
// register write-back
// selects destination index and value among execute, load and link
// -------------------------------------------------------------------------
module regWriteback (
    input  logic [0:4]  rs2Addr,
    input  logic [0:4]  rdAddr,
    input  logic        rType,
    input  logic        link,
    input  logic        memToReg,
    input  logic [0:31] execResult,
    input  logic [0:31] loadData,
    input  logic [0:31] linkAddr,
    output logic [0:4]  wrAddr,
    output logic [0:31] wrData
);

    // JAL always targets r31, immediate forms write rs2
    always_comb begin
        if (link) begin
            wrAddr = cpuPkg::linkReg;
        end else if (rType) begin
            wrAddr = rdAddr;
        end else begin
            wrAddr = rs2Addr;
        end
    end

    assign wrData = link ? linkAddr : (memToReg ? loadData : execResult);

endmodule

// File: logic/singleCycleCpu.sv
// -------------------------------------------------------------------------
// single-cycle core top
// wires decode, PC, register file, execute, load and write-back together
// -------------------------------------------------------------------------
module singleCycleCpu (
    input  logic             clk,
    input  logic             rstN,
    input  logic [0:31]      instr,
    input  logic [0:31]      dmemRData,
    output logic [0:31]      instrAddr,
    output logic [0:31]      dmemAddr,
    output logic [0:31]      dmemWData,
    output logic             dmemWe,
    output cpuPkg::dataSizeE dmemSize
);

    // instruction fields
    logic [0:4] rs1, rs2, rd;
    logic [0:15] imm16;
    logic [0:25] imm26;
    // control
    logic rType, regWrite, memToReg, memWrite, loadSigned, isMul, zeroExt, isLhi;
    logic branch, branchOnZero, jump, jumpReg, link;
    cpuPkg::aluOpE aluOp;
    cpuPkg::dataSizeE dataSize;
    // data path
    logic [0:31] busA, busB, immExt, linkAddr, loadData, wrData;
    logic [0:4] wrAddr;

    execIf exBus ();

    assign rs1 = instr[cpuPkg::rs1Pos +: cpuPkg::regIdxWidth];
    assign rs2 = instr[cpuPkg::rs2Pos +: cpuPkg::regIdxWidth];
    assign rd = instr[cpuPkg::rdPos +: cpuPkg::regIdxWidth];
    assign imm16 = instr[cpuPkg::imm16Pos +: 16];
    assign imm26 = instr[cpuPkg::imm26Pos +: 26];

    instrDecoder i_instrDecoder (
        .rstN(rstN), .instr(instr), .rType(rType), .regWrite(regWrite),
        .memToReg(memToReg), .memWrite(memWrite), .loadSigned(loadSigned),
        .dataSize(dataSize), .aluOp(aluOp), .isMul(isMul), .zeroExt(zeroExt),
        .isLhi(isLhi), .branch(branch), .branchOnZero(branchOnZero),
        .jump(jump), .jumpReg(jumpReg), .link(link)
    );

    registerFile i_registerFile (
        .clk(clk), .rstN(rstN), .rdAddrA(rs1), .rdAddrB(rs2),
        .wrAddr(wrAddr), .wrData(wrData), .wrEn(regWrite),
        .busA(busA), .busB(busB)
    );

    pcLogic i_pcLogic (
        .clk(clk), .rstN(rstN), .imm16(imm16), .imm26(imm26), .busA(busA),
        .branch(branch), .branchOnZero(branchOnZero), .jump(jump),
        .jumpReg(jumpReg), .pc(instrAddr), .linkAddr(linkAddr)
    );

    // ------------------------------------------------------------------------
    // operand selection
    // ------------------------------------------------------------------------
    assign immExt = zeroExt ? {16'b0, imm16} : {{16{imm16[0]}}, imm16};
    // LHI shifts the raw immediate left by a fixed 16
    assign exBus.operandA = isLhi ? {16'b0, imm16} : busA;
    assign exBus.operandB = isLhi ? cpuPkg::lhiShift : (rType ? busB : immExt);
    assign exBus.aluOp = aluOp;
    assign exBus.isMul = isMul;

    executeUnit i_executeUnit (.ex(exBus));

    loadAligner i_loadAligner (
        .rawData(dmemRData), .byteOffset(exBus.result[30:31]), .dataSize(dataSize),
        .loadSigned(loadSigned), .loadData(loadData)
    );

    regWriteback i_regWriteback (
        .rs2Addr(rs2), .rdAddr(rd), .rType(rType), .link(link), .memToReg(memToReg),
        .execResult(exBus.result), .loadData(loadData), .linkAddr(linkAddr),
        .wrAddr(wrAddr), .wrData(wrData)
    );

    // data memory side
    assign dmemAddr = exBus.result;
    assign dmemWData = busB;
    assign dmemWe = memWrite;
    assign dmemSize = dataSize;

endmodule

// File: sim/tbProgram.svh
// -------------------------------------------------------------------------
// test program and expected result stores for the core testbench
// one word per instruction, stores to 0x40 and up are checked in order,
// stores of the poison value 0xBAD go to 0xFC which lies past the table
// -------------------------------------------------------------------------
`ifndef tbProgramSvh
`define tbProgramSvh

localparam int progLen = 87;
localparam int numChecks = 32;

localparam logic [0:31] progWords [0:progLen-1] = '{
    // sw r0 to scratch word 0x10, this store sits at address 0 while reset is held
    32'hAC000010,
    // addi r1,r0,-5  ori r2,r0,0x8425  add r3  sub r4  and r5  or r6
    32'h2001FFFB, 32'h34028425, 32'h00221820, 32'h00412022, 32'h00222824, 32'h00223025,
    // xor r7  andi r8,r1,0x8F0F  then sw r3..r8, r1, r2 to 0x40..0x5C
    32'h00223826, 32'h30288F0F, 32'hAC030040, 32'hAC040044, 32'hAC050048, 32'hAC06004C,
    32'hAC070050, 32'hAC080054, 32'hAC010058, 32'hAC02005C,
    // addi r9,4  lhi r10,0x8123  sra r3  srl r4  sll r5  slt r6,r1,r9
    32'h20090004, 32'h3C0A8123, 32'h01491807, 32'h01492006, 32'h01492804, 32'h0029302A,
    // slt r7,r9,r1  mult r8,r1,r2  then sw r10, r3..r8 to 0x60..0x78
    32'h0121382A, 32'h0022400E, 32'hAC0A0060, 32'hAC030064, 32'hAC040068, 32'hAC05006C,
    32'hAC060070, 32'hAC070074, 32'hAC080078,
    // r11 = 0x81F27384, stored to scratch word 0x10
    32'h3C0B81F2, 32'h356B7384, 32'hAC0B0010,
    // lb at offsets 0..3, each copied to the result area
    32'h80030010, 32'hAC03007C, 32'h80030011, 32'hAC030080, 32'h80030012, 32'hAC030084,
    32'h80030013, 32'hAC030088, 32'h90030010, 32'hAC03008C, 32'h90030011, 32'hAC030090,
    // rest of lbu, then lh at 0 and 2
    32'h90030012, 32'hAC030094, 32'h90030013, 32'hAC030098, 32'h84030010, 32'hAC03009C,
    32'h84030012, 32'hAC0300A0, 32'h94030010, 32'hAC0300A4, 32'h94030012, 32'hAC0300A8,
    // lw, sb r9 into byte 1, lw of the merged word
    32'h8C030010, 32'hAC0300AC, 32'hA0090011, 32'h8C030010, 32'hAC0300B0,
    // r12 = poison, beqz r0 taken, beqz r1 not taken, bnez r1 taken
    32'h200C0BAD, 32'h10000004, 32'hAC0C00FC, 32'h10200004, 32'h200D0011, 32'h14200004,
    // bnez r0 not taken, r13 = 0x33 only if both fall-through paths ran
    32'hAC0C00FC, 32'h14000004, 32'h21AD0022, 32'hAC0D00B4,
    // j +4, jal +8 from 0x130, store r31
    32'h08000004, 32'hAC0C00FC, 32'h0C000008, 32'hAC0C00FC, 32'hAC0C00FC, 32'hAC1F00B8,
    // jr to 0x150, write r0, store r0
    32'h200E0150, 32'h49C00000, 32'hAC0C00FC, 32'hAC0C00FC, 32'h20000077, 32'hAC0000BC,
    // j to itself
    32'h0BFFFFFC
};

localparam logic [0:31] expectedStores [0:numChecks-1] = '{
    // add, sub, and, or, xor, andi, addi, ori
    32'h00008420, 32'h0000842A, 32'h00008421, 32'hFFFFFFFF,
    32'hFFFF7BDE, 32'h00008F0B, 32'hFFFFFFFB, 32'h00008425,
    // lhi, sra, srl, sll, slt, slt, mult
    32'h81230000, 32'hF8123000, 32'h08123000, 32'h12300000,
    32'h00000001, 32'h00000000, 32'hFFFD6B47,
    // lb x4, lbu x4
    32'hFFFFFF81, 32'hFFFFFFF2, 32'h00000073, 32'hFFFFFF84,
    32'h00000081, 32'h000000F2, 32'h00000073, 32'h00000084,
    // lh x2, lhu x2, lw, word after sb
    32'hFFFF81F2, 32'h00007384, 32'h000081F2, 32'h00007384,
    32'h81F27384, 32'h81047384,
    // branch marker, jal link, r0
    32'h00000033, 32'h00000134, 32'h00000000
};

`endif

// File: sim/cpuTb.sv
// -------------------------------------------------------------------------
// core testbench
// runs a fixed program against ROM and data memory models and checks
// every store into the result area, plus the reset behavior
// -------------------------------------------------------------------------
module cpuTb;

    timeunit 1ns;
    timeprecision 1ps;

    `include "tbProgram.svh"

    // result area starts at byte 0x40, one word per check
    localparam logic [0:31] resultBase = 32'h40;
    localparam logic [0:31] endPc = 32'((progLen - 1) * 4);
    localparam int timeoutCycles = progLen * 4 + 50;

    logic clk = 1'b0;
    logic rstN;
    logic [0:31] instr;
    logic [0:31] dmemRData;
    logic [0:31] instrAddr;
    logic [0:31] dmemAddr;
    logic [0:31] dmemWData;
    logic dmemWe;
    cpuPkg::dataSizeE dmemSize;

    logic [0:31] dataMem [0:63];
    logic [0:5] wordIdx;
    logic [0:6] romIdx;
    logic firstCycleDone = 1'b0;
    int errors = 0;
    int storeCount = 0;
    int cycles = 0;

    always #5 clk = ~clk;

    singleCycleCpu i_singleCycleCpu (
        .clk(clk), .rstN(rstN), .instr(instr), .dmemRData(dmemRData),
        .instrAddr(instrAddr), .dmemAddr(dmemAddr), .dmemWData(dmemWData),
        .dmemWe(dmemWe), .dmemSize(dmemSize)
    );

    // -----------------------------------------------------------------------
    // memory models
    // -----------------------------------------------------------------------
    // past the program end the ROM reads as a no-op
    assign romIdx = instrAddr[23:29];
    assign instr = (romIdx < progLen) ? progWords[romIdx] : 32'h0;

    assign wordIdx = dmemAddr[24:29];
    assign dmemRData = dataMem[wordIdx];

    initial begin
        for (int i = 0; i < 64; i++) begin
            dataMem[i] = 32'h5A00_0000 | (i * 32'h0001_0203);
        end
    end

    always @(posedge clk) begin
        if (dmemWe) begin
            if (dmemSize == cpuPkg::sizeByte) begin
                // big-endian lanes, offset 0 is the top byte
                case (dmemAddr[30:31])
                    2'd0: dataMem[wordIdx][0:7] <= dmemWData[24:31];
                    2'd1: dataMem[wordIdx][8:15] <= dmemWData[24:31];
                    2'd2: dataMem[wordIdx][16:23] <= dmemWData[24:31];
                    default: dataMem[wordIdx][24:31] <= dmemWData[24:31];
                endcase
            end else begin
                dataMem[wordIdx] <= dmemWData;
            end
        end
    end

    // -----------------------------------------------------------------------
    // checks, sampled mid-cycle when the combinational paths have settled
    // -----------------------------------------------------------------------
    always @(negedge clk) begin
        int slot;
        if (!rstN) begin
            assert (dmemWe == 1'b0) else begin
                errors++;
                $display("FAIL %0t dmemWe: expected 0, got %b", $time, dmemWe);
            end
        end else if (!firstCycleDone) begin
            firstCycleDone = 1'b1;
            assert (instrAddr == 32'h0) else begin
                errors++;
                $display("FAIL %0t instrAddr: expected %h, got %h", $time, 32'h0, instrAddr);
            end
        end
        if (rstN && dmemWe && dmemAddr >= resultBase) begin
            slot = int'((dmemAddr - resultBase) >> 2);
            storeCount++;
            // poison stores land past the table
            assert (slot < numChecks) else begin
                errors++;
                $display("store of %h to unchecked address %h at %0t", dmemWData, dmemAddr,
                    $time);
            end
            if (slot < numChecks) begin
                assert (dmemWData == expectedStores[slot]) else begin
                    errors++;
                    $display("FAIL %0t dmemWData: expected %h, got %h", $time,
                        expectedStores[slot], dmemWData);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= timeoutCycles) begin
            $display("timeout, program did not reach its final jump in %0d cycles",
                timeoutCycles);
            $display("errors: %0d, result stores: %0d of %0d", errors, storeCount, numChecks);
            $display("Simulation failed");
            $finish;
        end
    end

    // -----------------------------------------------------------------------
    // reset, run to the final self jump, report
    // -----------------------------------------------------------------------
    initial begin
        rstN = 1'b0;
        repeat (4) @(posedge clk);
        rstN <= 1'b1;
        while (instrAddr != endPc) begin
            @(negedge clk);
        end
        @(negedge clk);
        // a skipped check store shows up as a short count
        assert (storeCount == numChecks) else begin
            errors++;
            $display("only %0d of %0d result stores were executed", storeCount, numChecks);
        end
        $display("errors: %0d, result stores: %0d of %0d", errors, storeCount, numChecks);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+sim
common/cpuPkg.sv
common/execIf.sv
logic/instrDecoder.sv
logic/registerFile.sv
logic/pcLogic.sv
execute/executeUnit.sv
logic/loadAligner.sv
logic/regWriteback.sv
logic/singleCycleCpu.sv
sim/cpuTb.sv

// File: run.sh
#!/bin/sh
# build the core and its testbench with Verilator, run, and check the output
cd "$(dirname "$0")" &&
verilator --binary --assert --timescale 1ns/1ps -Wno-fatal --top-module cpuTb -f tb.f &&
./obj_dir/VcpuTb | tee /dev/stderr | grep -q "Simulation completed successfully" &&
echo "run.sh: pass" || { echo "run.sh: fail"; exit 1; }
